//--- build.f
hdl/trace_cfg_pkg.sv
hdl/trace_pkt_pkg.sv
hdl/ctrl_regs.sv
hdl/addr_window.sv
hdl/trigger_tracker.sv
hdl/trace_packer.sv
hdl/trace_fifo.sv
hdl/trace_monitor_top.sv
verification/tb_clock.sv
verification/tb_trace_monitor.sv

//--- hdl/addr_window.sv
//////////////////////////////////////////////////
// address window stage
// registers the sample and flags pc in range
//////////////////////////////////////////////////

`timescale 1ns/1ps

module addr_window import trace_cfg_pkg::*, trace_pkt_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  sample_t       sample,
    input  trace_cfg_t    cfg,
    output window_stage_t win
);

    logic                   valid_q;
    logic                   in_win_q;
    logic [XLEN-1:0]        pc_q;
    logic [INSTR_WIDTH-1:0] instr_q;
    logic                   lower_ok;
    logic                   upper_ok;

    // inclusive bounds, a disabled bound always passes
    assign lower_ok = !cfg.lower_en || (sample.pc >= cfg.lower_bound);
    assign upper_ok = !cfg.upper_en || (sample.pc <= cfg.upper_bound);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            in_win_q <= 1'b0;
        end else begin
            valid_q  <= sample.valid;
            in_win_q <= lower_ok && upper_ok;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        pc_q    <= sample.pc;
        instr_q <= sample.instr;
    end

    assign win = '{smp: '{valid: valid_q, pc: pc_q, instr: instr_q}, in_window: in_win_q};

endmodule

//--- hdl/ctrl_regs.sv
//////////////////////////////////////////////////
// control register file
// level triggered host writes, clear pulses
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_regs import trace_cfg_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_wr_t   ctrl_wr,
    output trace_cfg_t cfg,
    output logic       wfi_clear,
    output logic       ovf_clear
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // triggers and bounds off, window wide open
            cfg.start_en    <= 1'b0;
            cfg.end_en      <= 1'b0;
            cfg.start_addr  <= '0;
            cfg.end_addr    <= '1;
            cfg.lower_en    <= 1'b0;
            cfg.upper_en    <= 1'b0;
            cfg.lower_bound <= '0;
            cfg.upper_bound <= '1;
            wfi_clear       <= 1'b0;
            ovf_clear       <= 1'b0;
        end else begin
            // clears only last one cycle
            wfi_clear <= 1'b0;
            ovf_clear <= 1'b0;
            if (ctrl_wr.wr) begin
                case (ctrl_wr.addr)
                    START_EN:       cfg.start_en    <= ctrl_wr.data[0];
                    END_EN:         cfg.end_en      <= ctrl_wr.data[0];
                    START_ADDR:     cfg.start_addr  <= ctrl_wr.data;
                    END_ADDR:       cfg.end_addr    <= ctrl_wr.data;
                    LOWER_EN:       cfg.lower_en    <= ctrl_wr.data[0];
                    UPPER_EN:       cfg.upper_en    <= ctrl_wr.data[0];
                    LOWER_BOUND:    cfg.lower_bound <= ctrl_wr.data;
                    UPPER_BOUND:    cfg.upper_bound <= ctrl_wr.data;
                    WFI_CLEAR:      wfi_clear       <= 1'b1;
                    OVERFLOW_CLEAR: ovf_clear       <= 1'b1;
                    // unmapped address, write is lost
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hdl/trace_cfg_pkg.sv
//////////////////////////////////////////////////
// trace configuration package
// widths, wfi encoding, control map and the
// configuration register layout
//////////////////////////////////////////////////

package trace_cfg_pkg;

    // datapath widths
    localparam int XLEN        = 32;
    localparam int INSTR_WIDTH = 32;
    localparam int DELTA_WIDTH = 32;

    // packet buffer
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    // wfi handling, two wfi samples still go out
    localparam logic [INSTR_WIDTH-1:0] WFI_INSTR = 32'h1050_0073;
    localparam int WFI_TRACE_LIMIT = 2;
    localparam int WFI_CNT_WIDTH   = $clog2(WFI_TRACE_LIMIT + 1);

    // control register map
    typedef enum logic [3:0] {
        START_EN       = 4'd0,
        END_EN         = 4'd1,
        START_ADDR     = 4'd2,
        END_ADDR       = 4'd3,
        LOWER_EN       = 4'd4,
        UPPER_EN       = 4'd5,
        LOWER_BOUND    = 4'd6,
        UPPER_BOUND    = 4'd7,
        WFI_CLEAR      = 4'd8,
        OVERFLOW_CLEAR = 4'd9
    } ctrl_addr_e;

    // host write request
    typedef struct packed {
        logic        wr;
        ctrl_addr_e  addr;
        logic [31:0] data;
    } ctrl_wr_t;

    // live configuration
    typedef struct packed {
        logic            start_en;
        logic            end_en;
        logic [XLEN-1:0] start_addr;
        logic [XLEN-1:0] end_addr;
        logic            lower_en;
        logic            upper_en;
        logic [XLEN-1:0] lower_bound;
        logic [XLEN-1:0] upper_bound;
    } trace_cfg_t;

endpackage

//--- hdl/trace_fifo.sv
//////////////////////////////////////////////////
// packet fifo
// drop on full, sticky overflow, stream output
//////////////////////////////////////////////////

`timescale 1ns/1ps

module trace_fifo import trace_cfg_pkg::*, trace_pkt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  trace_beat_t wr_beat,
    input  logic        ovf_clear,
    output logic        out_valid,
    input  logic        out_ready,
    output trace_beat_t out_beat,
    output logic        overflow
);

    trace_beat_t               mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   count;
    logic                      full;
    logic                      push;
    logic                      pop;

    assign full = (count == FIFO_DEPTH);
    // a write into a full buffer is lost, even on a pop cycle
    assign push = wr_en && !full;
    assign pop  = out_valid && out_ready;

    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // pointers wrap, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // new drop beats a clear in the same cycle
            if (ovf_clear) begin
                overflow <= 1'b0;
            end
            if (wr_en && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/trace_monitor_top.sv
//////////////////////////////////////////////////
// trace monitor top
// filters retired instructions into a packet stream
//////////////////////////////////////////////////

`timescale 1ns/1ps

module trace_monitor_top import trace_cfg_pkg::*, trace_pkt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  sample_t     sample,
    input  logic        en,
    input  ctrl_wr_t    ctrl_wr,
    output logic        out_valid,
    input  logic        out_ready,
    output trace_beat_t out_beat,
    output logic        overflow
);

    trace_cfg_t    cfg;
    logic          wfi_clear;
    logic          ovf_clear;
    window_stage_t win;
    trig_stage_t   trig;
    logic          wr_en;
    trace_beat_t   wr_beat;

    ctrl_regs i_ctrl_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl_wr   (ctrl_wr),
        .cfg       (cfg),
        .wfi_clear (wfi_clear),
        .ovf_clear (ovf_clear)
    );

    // window and trigger stages see the same sample on the same edge
    addr_window i_addr_window (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .cfg    (cfg),
        .win    (win)
    );

    trigger_tracker i_trigger_tracker (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (sample),
        .cfg       (cfg),
        .wfi_clear (wfi_clear),
        .en        (en),
        .trig      (trig)
    );

    trace_packer i_trace_packer (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .win     (win),
        .trig    (trig),
        .wr_en   (wr_en),
        .wr_beat (wr_beat)
    );

    trace_fifo i_trace_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_beat   (wr_beat),
        .ovf_clear (ovf_clear),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .overflow  (overflow)
    );

endmodule

//--- hdl/trace_packer.sv
//////////////////////////////////////////////////
// trace packer
// keep decision, cycle delta stamp, packet build
//////////////////////////////////////////////////

`timescale 1ns/1ps

module trace_packer import trace_cfg_pkg::*, trace_pkt_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          en,
    input  window_stage_t win,
    input  trig_stage_t   trig,
    output logic          wr_en,
    output trace_beat_t   wr_beat
);

    logic [DELTA_WIDTH-1:0] cycle_cnt;
    logic [DELTA_WIDTH-1:0] last_ts;
    logic [DELTA_WIDTH-1:0] delta;

    // both stages must agree, plus the global enable
    assign wr_en = win.smp.valid && en && win.in_window && trig.active;

    // cycles since the previous kept packet
    assign delta = cycle_cnt - last_ts;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            last_ts   <= '0;
        end else begin
            // free running, wraps
            cycle_cnt <= cycle_cnt + 1'b1;
            if (wr_en) begin
                last_ts <= cycle_cnt;
            end
        end
    end

    assign wr_beat.last      = trig.last;
    assign wr_beat.pkt.instr = win.smp.instr;
    assign wr_beat.pkt.delta = delta;
    assign wr_beat.pkt.pc    = win.smp.pc;

endmodule

//--- hdl/trace_pkt_pkg.sv
//////////////////////////////////////////////////
// trace packet package
// sample, stage and packet types of the datapath
//////////////////////////////////////////////////

package trace_pkt_pkg;
    import trace_cfg_pkg::*;

    // retired instruction from the core
    typedef struct packed {
        logic                   valid;
        logic [XLEN-1:0]        pc;
        logic [INSTR_WIDTH-1:0] instr;
    } sample_t;

    // sample after the window stage
    typedef struct packed {
        sample_t smp;
        logic    in_window;
    } window_stage_t;

    // trigger stage decision
    typedef struct packed {
        logic active;
        // set on wfi samples
        logic last;
    } trig_stage_t;

    typedef struct packed {
        logic [INSTR_WIDTH-1:0] instr;
        logic [DELTA_WIDTH-1:0] delta;
        logic [XLEN-1:0]        pc;
    } trace_pkt_t;

    // one beat on the output stream
    typedef struct packed {
        logic       last;
        trace_pkt_t pkt;
    } trace_beat_t;

endpackage

//--- hdl/trigger_tracker.sv
//////////////////////////////////////////////////
// trigger tracker
// start/end trigger session and wfi stop counter
//////////////////////////////////////////////////

`timescale 1ns/1ps

module trigger_tracker import trace_cfg_pkg::*, trace_pkt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  sample_t     sample,
    input  trace_cfg_t  cfg,
    input  logic        wfi_clear,
    input  logic        en,
    output trig_stage_t trig
);

    logic                     start_reached;
    logic                     end_reached;
    logic [WFI_CNT_WIDTH-1:0] wfi_cnt;
    logic                     is_wfi;
    logic                     hit_start;
    logic                     hit_end;
    logic                     session_open;
    logic                     wfi_stop;

    assign is_wfi    = sample.valid && (sample.instr == WFI_INSTR);
    assign hit_start = sample.valid && cfg.start_en && (sample.pc == cfg.start_addr);
    assign hit_end   = sample.valid && cfg.end_en && (sample.pc == cfg.end_addr);

    // state before this sample, so start sample is out and end sample is in
    assign session_open = (start_reached || !cfg.start_en) && (!end_reached || !cfg.end_en);
    // a non-wfi sample resets the count, so only wfi samples get blocked
    assign wfi_stop = is_wfi && (wfi_cnt >= WFI_TRACE_LIMIT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_reached <= 1'b0;
            end_reached   <= 1'b0;
            wfi_cnt       <= '0;
            trig          <= '0;
        end else begin
            trig.active <= session_open && !wfi_stop;
            trig.last   <= is_wfi;
            if (hit_start) begin
                start_reached <= 1'b1;
                end_reached   <= 1'b0;
            end
            // end wins if both addresses match
            if (hit_end) begin
                end_reached   <= 1'b1;
                start_reached <= 1'b0;
            end
            // saturating count of back to back wfi
            if (wfi_clear) begin
                wfi_cnt <= '0;
            end else if (sample.valid && !is_wfi) begin
                wfi_cnt <= '0;
            end else if (is_wfi && en && (wfi_cnt < WFI_TRACE_LIMIT)) begin
                wfi_cnt <= wfi_cnt + 1'b1;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the trace monitor testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_trace_monitor \
    -f build.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

//--- verification/tb_clock.sv
//////////////////////////////////////////////////
// testbench clock and reset
// 8 ns clock, reset low for three cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // synchronous reset, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verification/tb_trace_monitor.sv
//////////////////////////////////////////////////
// trace monitor testbench
// directed tests against a queue of expected beats
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_trace_monitor import trace_cfg_pkg::*, trace_pkt_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] NOP = 32'h0000_0013;

    // expected beat, delta unknown before the first kept sample
    typedef struct packed {
        trace_beat_t beat;
        logic        chk_delta;
    } exp_beat_t;

    logic        clk;
    logic        rst_n;
    sample_t     sample;
    logic        en;
    ctrl_wr_t    ctrl_wr;
    logic        out_valid;
    logic        out_ready;
    trace_beat_t out_beat;
    logic        overflow;

    exp_beat_t              exp_q[$];
    exp_beat_t              mon_exp;
    logic [DELTA_WIDTH-1:0] cyc_now = '0;
    logic [DELTA_WIDTH-1:0] last_keep = '0;
    logic                   have_prev = 1'b0;
    int                     timeout_cnt = 0;
    int                     seed = 30309;

    tb_clock i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    trace_monitor_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (sample),
        .en        (en),
        .ctrl_wr   (ctrl_wr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .overflow  (overflow)
    );

    task automatic abort_run;
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_error(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
        abort_run();
    endtask

    task automatic check_pkt(input trace_pkt_t got, input trace_pkt_t want,
                             input logic chk_delta);
        if (got.pc !== want.pc) report_error("out_beat.pkt.pc", got.pc, want.pc);
        if (got.instr !== want.instr) report_error("out_beat.pkt.instr", got.instr, want.instr);
        if (chk_delta && (got.delta !== want.delta)) begin
            report_error("out_beat.pkt.delta", got.delta, want.delta);
        end
    endtask

    task automatic check_last(input logic got, input logic want);
        if (got !== want) report_error("out_beat.last", 32'(got), 32'(want));
    endtask

    task automatic check_overflow(input logic got, input logic want);
        if (got !== want) report_error("overflow", 32'(got), 32'(want));
    endtask

    // one cycle, sample idle unless the caller drives it again
    task automatic tick;
        @(posedge clk);
        cyc_now = cyc_now + 1'b1;
        sample <= '0;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    // drive one sample; kept ones move the delta base, stored ones are expected
    task automatic send(input logic [XLEN-1:0] pc, input logic [INSTR_WIDTH-1:0] instr,
                        input logic keep, input logic store);
        exp_beat_t e;
        tick();
        sample <= '{valid: 1'b1, pc: pc, instr: instr};
        if (keep) begin
            e.beat.last      = (instr == WFI_INSTR);
            e.beat.pkt.instr = instr;
            e.beat.pkt.pc    = pc;
            e.beat.pkt.delta = cyc_now - last_keep;
            e.chk_delta      = have_prev;
            have_prev        = 1'b1;
            last_keep        = cyc_now;
            if (store) exp_q.push_back(e);
        end
    endtask

    task automatic write_ctrl(input ctrl_addr_e addr, input logic [31:0] data);
        tick();
        ctrl_wr <= '{wr: 1'b1, addr: addr, data: data};
        tick();
        ctrl_wr <= '0;
    endtask

    // empty queue, then a few quiet cycles so a stray beat shows up
    task automatic wait_drain;
        while (exp_q.size() != 0) tick();
        idle(4);
    endtask

    task automatic default_stream;
        logic [31:0] rnd_pc;
        logic [31:0] rnd_instr;
        for (int i = 0; i < 6; i++) begin
            rnd_pc    = $random(seed);
            rnd_instr = $random(seed);
            // addi opcode, never a wfi
            send({rnd_pc[31:2], 2'b00}, {rnd_instr[31:7], 7'h13}, 1'b1, 1'b1);
            idle(i);
        end
        wait_drain();
    endtask

    task automatic window_filter;
        write_ctrl(LOWER_BOUND, 32'h0000_1000);
        write_ctrl(UPPER_BOUND, 32'h0000_1ffc);
        write_ctrl(LOWER_EN, 32'd1);
        write_ctrl(UPPER_EN, 32'd1);
        send(32'h0000_0ffc, NOP, 1'b0, 1'b0);
        send(32'h0000_1000, NOP, 1'b1, 1'b1);
        idle(2);
        send(32'h0000_1800, NOP, 1'b1, 1'b1);
        send(32'h0000_2000, NOP, 1'b0, 1'b0);
        idle(1);
        send(32'h0000_1ffc, NOP, 1'b1, 1'b1);
        send(32'h0000_2004, NOP, 1'b0, 1'b0);
        send(32'h0000_1004, NOP, 1'b1, 1'b1);
        wait_drain();
        write_ctrl(LOWER_EN, 32'd0);
        write_ctrl(UPPER_EN, 32'd0);
    endtask

    task automatic trigger_session;
        write_ctrl(START_ADDR, 32'h0000_0100);
        write_ctrl(END_ADDR, 32'h0000_0200);
        write_ctrl(START_EN, 32'd1);
        write_ctrl(END_EN, 32'd1);
        // session closed until start is seen, start sample itself dropped
        send(32'h0000_0080, NOP, 1'b0, 1'b0);
        send(32'h0000_0100, NOP, 1'b0, 1'b0);
        send(32'h0000_0104, NOP, 1'b1, 1'b1);
        idle(1);
        send(32'h0000_0108, NOP, 1'b1, 1'b1);
        send(32'h0000_0200, NOP, 1'b1, 1'b1);
        send(32'h0000_0204, NOP, 1'b0, 1'b0);
        send(32'h0000_0208, NOP, 1'b0, 1'b0);
        send(32'h0000_0100, NOP, 1'b0, 1'b0);
        send(32'h0000_010c, NOP, 1'b1, 1'b1);
        wait_drain();
        write_ctrl(START_EN, 32'd0);
        write_ctrl(END_EN, 32'd0);
    endtask

    task automatic wfi_stop;
        // only the first two wfi of a run get out
        for (int k = 0; k < 5; k++) begin
            send(32'h0000_0300 + 4 * k, WFI_INSTR, k < WFI_TRACE_LIMIT, k < WFI_TRACE_LIMIT);
        end
        send(32'h0000_0314, NOP, 1'b1, 1'b1);
        // two more wfi use up the count, a clear reopens it
        send(32'h0000_0318, WFI_INSTR, 1'b1, 1'b1);
        send(32'h0000_031c, WFI_INSTR, 1'b1, 1'b1);
        write_ctrl(WFI_CLEAR, 32'd0);
        send(32'h0000_0320, WFI_INSTR, 1'b1, 1'b1);
        wait_drain();
    endtask

    task automatic overflow_drop;
        tick();
        out_ready <= 1'b0;
        @(negedge clk);
        check_overflow(overflow, 1'b0);
        // all ten pass the packer, only the first eight fit
        for (int k = 0; k < 10; k++) begin
            send(32'h0000_0400 + 4 * k, NOP, 1'b1, k < FIFO_DEPTH);
        end
        idle(3);
        @(negedge clk);
        check_overflow(overflow, 1'b1);
        tick();
        out_ready <= 1'b1;
        wait_drain();
        @(negedge clk);
        check_overflow(overflow, 1'b1);
        write_ctrl(OVERFLOW_CLEAR, 32'd0);
        idle(2);
        @(negedge clk);
        check_overflow(overflow, 1'b0);
    endtask

    task automatic disabled_monitor;
        tick();
        en <= 1'b0;
        for (int k = 0; k < 4; k++) begin
            send(32'h0000_0500 + 4 * k, NOP, 1'b0, 1'b0);
        end
        idle(4);
        wait_drain();
        tick();
        en <= 1'b1;
    endtask

    // stream checker, a beat moves on the next edge when valid and ready
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: beat on the output stream with none expected", $time);
                abort_run();
            end else begin
                mon_exp = exp_q.pop_front();
                check_pkt(out_beat.pkt, mon_exp.beat.pkt, mon_exp.chk_delta);
                check_last(out_beat.last, mon_exp.beat.last);
            end
        end
    end

    always @(posedge clk) begin
        timeout_cnt <= timeout_cnt + 1;
        if (timeout_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        sample    = '0;
        en        = 1'b1;
        ctrl_wr   = '0;
        out_ready = 1'b1;
        wait (rst_n);
        idle(2);
        default_stream();
        window_filter();
        trigger_session();
        wfi_stop();
        overflow_drop();
        disabled_monitor();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
